//--- bench/vec_control_unit_properties.sv
// --------------------------------------------------------------------------
// vector decode front end assertions
// input protocol, quiet output under reset and stall, and the unit
// selected for illegal instructions
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module vec_control_unit_properties
  import vec_ctrl_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     instr_valid,
  input logic     full,
  input logic     stall,
  input logic     ctrl_valid,
  input logic     illegal,
  input fu_type_t fu_type
);

  int fail_count = 0;

  no_push_when_full: assert property (
    @(posedge clk) disable iff (reset) !(instr_valid && full)
  ) else begin
    $error("instr_valid strobed while the queue is full");
    fail_count++;
  end

  quiet_in_reset: assert property (@(posedge clk) reset |=> !ctrl_valid)
  else begin
    $error("ctrl_valid high after a reset cycle");
    fail_count++;
  end

  // a stalled cycle never pops, so the next cycle has no output
  quiet_after_stall: assert property (@(posedge clk) stall |=> !ctrl_valid)
  else begin
    $error("ctrl_valid high one cycle after stall");
    fail_count++;
  end

  illegal_on_arith: assert property (
    @(posedge clk) disable iff (reset) (ctrl_valid && illegal) |-> (fu_type == ARITH)
  ) else begin
    $error("illegal instruction sent to a unit other than ARITH");
    fail_count++;
  end

endmodule

bind vec_control_unit vec_control_unit_properties vec_control_unit_properties_i (
  .clk         (clk),
  .reset       (reset),
  .instr_valid (instr_valid),
  .full        (full),
  .stall       (stall),
  .ctrl_valid  (ctrl_valid),
  .illegal     (illegal),
  .fu_type     (fu_type)
);

//--- bench/vec_control_unit_tb.sv
// --------------------------------------------------------------------------
// vector decode front end testbench
// exhaustive funct6/funct3 sweep, stall and latency checks and a random
// stream, all compared against a reference decode through a scoreboard
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module vec_control_unit_tb
  import vec_isa_pkg::*;
  import vec_ctrl_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 200;

  typedef struct packed {
    vec_op_t   op;
    fu_type_t  fu;
    aluop_t    alu;
    sew_t      eew;
    sew_t      vs2_sew;
    sign_t     is_signed;
    logic      single_bit_op;
    logic      illegal;
    reg_idx_t  vd;
    reg_idx_t  vs1;
    reg_idx_t  vs2;
    src_type_t rs1_type;
  } expected_t;

  logic      clk;
  logic      reset;
  logic      instr_valid;
  instr_t    instr;
  sew_t      vtype_sew;
  logic      stall;
  logic      full;
  logic      ctrl_valid;
  vec_op_t   ctrl_op;
  fu_type_t  fu_type;
  aluop_t    aluop;
  sew_t      eew;
  sew_t      vs2_sew;
  sign_t     is_signed;
  logic      single_bit_op;
  logic      illegal;
  reg_idx_t  vd;
  reg_idx_t  vs1;
  reg_idx_t  vs2;
  src_type_t rs1_type;

  expected_t   exp_q[$];
  expected_t   want;
  int          errors = 0;
  int          timeouts = 0;
  int          compared = 0;
  int          pushes;
  instr_t      w;

  vec_control_unit vec_control_unit_i (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .vtype_sew     (vtype_sew),
    .stall         (stall),
    .full          (full),
    .ctrl_valid    (ctrl_valid),
    .ctrl_op       (ctrl_op),
    .fu_type       (fu_type),
    .aluop         (aluop),
    .eew           (eew),
    .vs2_sew       (vs2_sew),
    .is_signed     (is_signed),
    .single_bit_op (single_bit_op),
    .illegal       (illegal),
    .vd            (vd),
    .vs1           (vs1),
    .vs2           (vs2),
    .rs1_type      (rs1_type)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic instr_t encode(logic [5:0] f6, vfunct3_t f3, reg_idx_t rd,
                                    reg_idx_t rs1, reg_idx_t rs2);
    instr_t x;
    x = '0;
    x[6:0] = VECTOR;
    x[VD_LSB +: 5] = rd;
    x[FUNCT3_LSB +: 3] = f3;
    x[VS1_LSB +: 5] = rs1;
    x[VS2_LSB +: 5] = rs2;
    x[FUNCT6_LSB +: 6] = f6;
    return x;
  endfunction

  function automatic instr_t rand_instr();
    instr_t x;
    x = $urandom();
    // mostly vector opcodes so the funct fields matter
    if ($urandom_range(7) != 0) begin
      x[6:0] = VECTOR;
    end
    return x;
  endfunction

  function automatic sew_t rand_sew();
    return sew_t'(3'($urandom_range(2)));
  endfunction

  function automatic expected_t decode_ref(instr_t x, sew_t s);
    expected_t e;
    logic [5:0] f6;
    logic [2:0] f3;
    logic       ok;
    vec_op_t    cand;
    sew_t       wide;
    f6 = x[FUNCT6_LSB +: 6];
    f3 = x[FUNCT3_LSB +: 3];
    cand = BAD_OP;
    ok = 1'b0;
    if (x[6:0] == VECTOR && (f3 == OPIVV || f3 == OPIVX || f3 == OPIVI)) begin
      case (f6)
        VADD:    cand = OP_VADD;
        VSUB:    cand = OP_VSUB;
        VRSUB:   cand = OP_VRSUB;
        VMINU:   cand = OP_VMINU;
        VMIN:    cand = OP_VMIN;
        VMAXU:   cand = OP_VMAXU;
        VMAX:    cand = OP_VMAX;
        VAND:    cand = OP_VAND;
        VOR:     cand = OP_VOR;
        VXOR:    cand = OP_VXOR;
        VMSEQ:   cand = OP_VMSEQ;
        VMSNE:   cand = OP_VMSNE;
        VMSLTU:  cand = OP_VMSLTU;
        VMSLT:   cand = OP_VMSLT;
        VSLL:    cand = OP_VSLL;
        VSRL:    cand = OP_VSRL;
        VSRA:    cand = OP_VSRA;
        default: cand = BAD_OP;
      endcase
      // vector-vector and vector-scalar only
      if (cand inside {OP_VSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX, OP_VMSLTU, OP_VMSLT}) begin
        ok = (f3 != OPIVI);
      end else if (cand == OP_VRSUB) begin
        ok = (f3 != OPIVV);
      end else begin
        ok = (cand != BAD_OP);
      end
    end else if (x[6:0] == VECTOR && (f3 == OPMVV || f3 == OPMVX)) begin
      case (f6)
        VREDSUM:  cand = OP_VREDSUM;
        VDIVU:    cand = OP_VDIVU;
        VDIV:     cand = OP_VDIV;
        VMUL:     cand = OP_VMUL;
        VMULH:    cand = OP_VMULH;
        VWADDU:   cand = OP_VWADDU;
        VWADD:    cand = OP_VWADD;
        VWADDU_W: cand = OP_VWADDU_W;
        default:  cand = BAD_OP;
      endcase
      ok = (cand == OP_VREDSUM) ? (f3 == OPMVV) : (cand != BAD_OP);
    end
    if (!ok) begin
      cand = BAD_OP;
    end
    e.op = cand;
    e.illegal = !ok;
    if (cand == OP_VREDSUM) begin
      e.fu = RED;
    end else if (cand == OP_VMUL || cand == OP_VMULH) begin
      e.fu = MUL;
    end else if (cand == OP_VDIVU || cand == OP_VDIV) begin
      e.fu = DIV;
    end else begin
      e.fu = ARITH;
    end
    if (!ok || e.fu == MUL || e.fu == DIV) begin
      e.alu = VALU_NONE;
    end else if (cand inside {OP_VADD, OP_VREDSUM, OP_VWADDU, OP_VWADD, OP_VWADDU_W}) begin
      e.alu = VALU_ADD;
    end else if (cand inside {OP_VSUB, OP_VRSUB}) begin
      e.alu = VALU_SUB;
    end else if (cand inside {OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX}) begin
      e.alu = VALU_MM;
    end else if (cand inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT}) begin
      e.alu = VALU_COMP;
    end else if (cand == OP_VAND) begin
      e.alu = VALU_AND;
    end else if (cand == OP_VOR) begin
      e.alu = VALU_OR;
    end else if (cand == OP_VXOR) begin
      e.alu = VALU_XOR;
    end else if (cand == OP_VSLL) begin
      e.alu = VALU_SLL;
    end else if (cand == OP_VSRL) begin
      e.alu = VALU_SRL;
    end else begin
      e.alu = VALU_SRA;
    end
    e.is_signed = (cand inside {OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ,
                                OP_VMSNE, OP_VMSLT, OP_VREDSUM, OP_VMUL, OP_VMULH, OP_VDIV,
                                OP_VWADD}) ? SIGNED : UNSIGNED;
    e.single_bit_op = cand inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT};
    // twice the width but never beyond 32 bits
    wide = (s == SEW8) ? SEW16 : SEW32;
    e.eew = (cand inside {OP_VWADDU, OP_VWADD, OP_VWADDU_W}) ? wide : s;
    e.vs2_sew = (cand == OP_VWADDU_W) ? wide : s;
    e.vd = x[VD_LSB +: 5];
    e.vs1 = x[VS1_LSB +: 5];
    e.vs2 = x[VS2_LSB +: 5];
    if (f3 == OPIVX || f3 == OPMVX) begin
      e.rs1_type = X;
    end else if (f3 == OPIVI) begin
      e.rs1_type = I;
    end else begin
      e.rs1_type = V;
    end
    return e;
  endfunction

  task automatic check_op(vec_op_t got, vec_op_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_fu(fu_type_t got, fu_type_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_alu(aluop_t got, aluop_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_sew(sew_t got, sew_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_sign(sign_t got, sign_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_src(src_type_t got, src_type_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(reg_idx_t got, reg_idx_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // one strobe from one falling edge to the next
  task automatic send(instr_t x, sew_t s);
    int cycles;
    cycles = 0;
    while (full && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (full) begin
      $display("timeout at %0t: queue stayed full, instruction not sent", $time);
      timeouts++;
    end else begin
      instr_valid = 1'b1;
      instr = x;
      vtype_sew = s;
      exp_q.push_back(decode_ref(x, s));
      @(negedge clk);
      instr_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout at %0t: %0d results never came out", $time, exp_q.size());
      timeouts++;
      exp_q.delete();
    end
  endtask

  // scoreboard samples away from the rising edge
  always @(negedge clk) begin
    if (!reset && ctrl_valid) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: ctrl_valid with no instruction outstanding", $time);
        errors++;
      end else begin
        want = exp_q.pop_front();
        compared++;
        check_op(ctrl_op, want.op, "ctrl_op");
        check_fu(fu_type, want.fu, "fu_type");
        check_alu(aluop, want.alu, "aluop");
        check_sew(eew, want.eew, "eew");
        check_sew(vs2_sew, want.vs2_sew, "vs2_sew");
        check_sign(is_signed, want.is_signed, "is_signed");
        check_flag(single_bit_op, want.single_bit_op, "single_bit_op");
        check_flag(illegal, want.illegal, "illegal");
        check_reg(vd, want.vd, "vd");
        check_reg(vs1, want.vs1, "vs1");
        check_reg(vs2, want.vs2, "vs2");
        check_src(rs1_type, want.rs1_type, "rs1_type");
      end
    end
  end

  initial begin
    void'($urandom(32));
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    vtype_sew = SEW8;
    stall = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_flag(ctrl_valid, 1'b0, "ctrl_valid after reset");
    check_flag(full, 1'b0, "full after reset");

    // every funct6 under every funct3 and every sew
    for (int s = 0; s < 3; s++) begin
      for (int f6 = 0; f6 < 64; f6++) begin
        for (int f3 = 0; f3 < 8; f3++) begin
          w = encode(6'(f6), vfunct3_t'(3'(f3)), 5'($urandom), 5'($urandom), 5'($urandom));
          send(w, sew_t'(3'(s)));
        end
      end
    end

    // other major opcodes
    repeat (32) begin
      w = $urandom();
      if (w[6:0] == VECTOR) begin
        w[6:0] = LOAD_FP;
      end
      send(w, rand_sew());
    end
    wait_drain();

    // fill under stall, then a back-to-back drain
    stall = 1'b1;
    pushes = 0;
    while (!full && pushes < 2 * QUEUE_DEPTH) begin
      send(rand_instr(), rand_sew());
      pushes++;
    end
    check_flag(pushes == QUEUE_DEPTH, 1'b1, "full after QUEUE_DEPTH pushes");
    check_flag(ctrl_valid, 1'b0, "ctrl_valid under stall");
    stall = 1'b0;
    repeat (QUEUE_DEPTH) begin
      @(negedge clk);
      check_flag(ctrl_valid, 1'b1, "ctrl_valid while draining");
    end
    wait_drain();

    // two cycles through an empty pipeline
    send(rand_instr(), rand_sew());
    check_flag(ctrl_valid, 1'b0, "ctrl_valid one cycle after strobe");
    @(negedge clk);
    check_flag(ctrl_valid, 1'b1, "ctrl_valid two cycles after strobe");
    wait_drain();

    // random stream under random stall
    repeat (400) begin
      stall = ($urandom_range(3) == 0);
      if (full || $urandom_range(9) < 3) begin
        @(negedge clk);
      end else begin
        send(rand_instr(), rand_sew());
      end
    end
    stall = 1'b0;
    wait_drain();
    repeat (4) @(negedge clk);

    $display("%0d results compared, %0d errors, %0d timeouts, %0d assertion failures",
             compared, errors, timeouts,
             vec_control_unit_i.vec_control_unit_properties_i.fail_count);
    if (errors == 0 && timeouts == 0 &&
        vec_control_unit_i.vec_control_unit_properties_i.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
src/vec_isa_pkg.sv
src/vec_ctrl_pkg.sv
src/vec_op_decoder.sv
src/vec_issue_queue.sv
src/vec_ctrl_gen.sv
src/vec_control_unit.sv
bench/vec_control_unit_properties.sv
bench/vec_control_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the vector decode front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f list.f \
  --top-module vec_control_unit_tb -o vec_control_unit_sim

# assertion errors are counted by the testbench instead of stopping the run
./obj_dir/vec_control_unit_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -qx "TESTS PASSED" sim.log

//--- src/vec_control_unit.sv
// --------------------------------------------------------------------------
// vector decode front end
// decoder, issue queue and execution control generator in series
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module vec_control_unit
  import vec_isa_pkg::*;
  import vec_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_valid,
  input  instr_t    instr,
  input  sew_t      vtype_sew,
  input  logic      stall,
  output logic      full,
  output logic      ctrl_valid,
  output vec_op_t   ctrl_op,
  output fu_type_t  fu_type,
  output aluop_t    aluop,
  output sew_t      eew,
  output sew_t      vs2_sew,
  output sign_t     is_signed,
  output logic      single_bit_op,
  output logic      illegal,
  output reg_idx_t  vd,
  output reg_idx_t  vs1,
  output reg_idx_t  vs2,
  output src_type_t rs1_type
);

  logic         push;
  logic         pop;
  logic         avail;
  vec_decoded_t entry;
  vec_decoded_t head;

  vec_op_decoder vec_op_decoder_i (
    .instr_valid (instr_valid),
    .instr       (instr),
    .vtype_sew   (vtype_sew),
    .push        (push),
    .entry       (entry)
  );

  vec_issue_queue vec_issue_queue_i (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .entry (entry),
    .pop   (pop),
    .full  (full),
    .avail (avail),
    .head  (head)
  );

  vec_ctrl_gen vec_ctrl_gen_i (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .avail         (avail),
    .head          (head),
    .pop           (pop),
    .ctrl_valid    (ctrl_valid),
    .ctrl_op       (ctrl_op),
    .fu_type       (fu_type),
    .aluop         (aluop),
    .eew           (eew),
    .vs2_sew       (vs2_sew),
    .is_signed     (is_signed),
    .single_bit_op (single_bit_op),
    .illegal       (illegal),
    .vd            (vd),
    .vs1           (vs1),
    .vs2           (vs2),
    .rs1_type      (rs1_type)
  );

endmodule

//--- src/vec_ctrl_gen.sv
// --------------------------------------------------------------------------
// vector execution control generator
// pops the queue head when not stalled and registers the unit, ALU op,
// widths, signedness and operand controls for the execute stage
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module vec_ctrl_gen
  import vec_isa_pkg::*;
  import vec_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         stall,
  input  logic         avail,
  input  vec_decoded_t head,
  output logic         pop,
  output logic         ctrl_valid,
  output vec_op_t      ctrl_op,
  output fu_type_t     fu_type,
  output aluop_t       aluop,
  output sew_t         eew,
  output sew_t         vs2_sew,
  output sign_t        is_signed,
  output logic         single_bit_op,
  output logic         illegal,
  output reg_idx_t     vd,
  output reg_idx_t     vs1,
  output reg_idx_t     vs2,
  output src_type_t    rs1_type
);

  fu_type_t fu_next;
  aluop_t   alu_next;
  sign_t    sign_next;
  logic     widen_vd;
  logic     widen_vs2;

  // double the element width, 32 is the widest supported
  function automatic sew_t widen(input sew_t sew);
    widen = (sew == SEW8) ? SEW16 : SEW32;
  endfunction

  assign pop = avail && !stall;

  assign widen_vd  = head.op inside {OP_VWADDU, OP_VWADD, OP_VWADDU_W};
  assign widen_vs2 = (head.op == OP_VWADDU_W);

  always_comb begin
    case (head.op)
      OP_VREDSUM:        fu_next = RED;
      OP_VMUL, OP_VMULH: fu_next = MUL;
      OP_VDIVU, OP_VDIV: fu_next = DIV;
      default:           fu_next = ARITH;
    endcase
  end

  always_comb begin
    case (head.op)
      OP_VADD, OP_VREDSUM, OP_VWADDU, OP_VWADD, OP_VWADDU_W: alu_next = VALU_ADD;
      OP_VSUB, OP_VRSUB:                                     alu_next = VALU_SUB;
      OP_VAND:                                               alu_next = VALU_AND;
      OP_VOR:                                                alu_next = VALU_OR;
      OP_VXOR:                                               alu_next = VALU_XOR;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX:                  alu_next = VALU_MM;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT:               alu_next = VALU_COMP;
      OP_VSLL:                                               alu_next = VALU_SLL;
      OP_VSRL:                                               alu_next = VALU_SRL;
      OP_VSRA:                                               alu_next = VALU_SRA;
      // mul/div units and illegal entries do not use the ALU
      default:                                               alu_next = VALU_NONE;
    endcase
  end

  always_comb begin
    case (head.op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ, OP_VMSNE, OP_VMSLT,
      OP_VREDSUM, OP_VMUL, OP_VMULH, OP_VDIV, OP_VWADD: sign_next = SIGNED;
      default:                                          sign_next = UNSIGNED;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_valid <= 1'b0;
    end else begin
      ctrl_valid <= pop;
    end
  end

  // controls hold their last values while stalled
  always_ff @(posedge clk) begin
    if (pop) begin
      ctrl_op       <= head.op;
      fu_type       <= fu_next;
      aluop         <= alu_next;
      is_signed     <= sign_next;
      single_bit_op <= head.op inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT};
      eew           <= widen_vd ? widen(head.sew) : head.sew;
      vs2_sew       <= widen_vs2 ? widen(head.sew) : head.sew;
      illegal       <= head.illegal;
      vd            <= head.vd;
      vs1           <= head.vs1;
      vs2           <= head.vs2;
      rs1_type      <= head.rs1_type;
    end
  end

endmodule

//--- src/vec_ctrl_pkg.sv
// --------------------------------------------------------------------------
// vector control types
// decoded operation, execution control encodings, the decoded entry
// carried through the issue queue and the queue sizing
// --------------------------------------------------------------------------
package vec_ctrl_pkg;

  typedef enum logic [7:0] {
    BAD_OP,
    OP_VADD,
    OP_VSUB,
    OP_VRSUB,
    OP_VMINU,
    OP_VMIN,
    OP_VMAXU,
    OP_VMAX,
    OP_VAND,
    OP_VOR,
    OP_VXOR,
    OP_VMSEQ,
    OP_VMSNE,
    OP_VMSLTU,
    OP_VMSLT,
    OP_VSLL,
    OP_VSRL,
    OP_VSRA,
    OP_VREDSUM,
    OP_VMUL,
    OP_VMULH,
    OP_VDIVU,
    OP_VDIV,
    OP_VWADDU,
    OP_VWADD,
    OP_VWADDU_W
  } vec_op_t;

  typedef enum logic [2:0] {
    SEW8  = 3'd0,
    SEW16 = 3'd1,
    SEW32 = 3'd2
  } sew_t;

  typedef enum logic [1:0] {ARITH, RED, MUL, DIV} fu_type_t;

  typedef enum logic [3:0] {
    VALU_ADD,
    VALU_SUB,
    VALU_AND,
    VALU_OR,
    VALU_XOR,
    VALU_MM,
    VALU_COMP,
    VALU_SLL,
    VALU_SRL,
    VALU_SRA,
    VALU_NONE
  } aluop_t;

  typedef enum logic {UNSIGNED = 1'b0, SIGNED = 1'b1} sign_t;

  // where the first operand comes from: vector reg, scalar reg or immediate
  typedef enum logic [1:0] {V, X, I} src_type_t;

  typedef struct packed {
    vec_op_t               op;
    sew_t                  sew;
    vec_isa_pkg::reg_idx_t vd;
    vec_isa_pkg::reg_idx_t vs1;
    vec_isa_pkg::reg_idx_t vs2;
    src_type_t             rs1_type;
    logic                  illegal;
  } vec_decoded_t;

  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_AW    = 2;

endpackage

//--- src/vec_isa_pkg.sv
// --------------------------------------------------------------------------
// vector ISA encoding
// opcode, funct3 category and funct6 codes of the kept vector integer
// operations, plus the bit positions of the instruction fields
// --------------------------------------------------------------------------
package vec_isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes, only VECTOR is decoded by this front end
  typedef enum logic [6:0] {
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111,
    VECTOR   = 7'b1010111
  } opcode_t;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // integer category funct6 codes
  typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
  } vopi_t;

  // mask/multiply category funct6 codes
  typedef enum logic [5:0] {
    VREDSUM  = 6'b000000,
    VDIVU    = 6'b100000,
    VDIV     = 6'b100001,
    VMUL     = 6'b100101,
    VMULH    = 6'b100111,
    VWADDU   = 6'b110000,
    VWADD    = 6'b110001,
    VWADDU_W = 6'b110100
  } vopm_t;

  // low bit of each field in the instruction word
  localparam int VD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int VS1_LSB    = 15;
  localparam int VS2_LSB    = 20;
  localparam int FUNCT6_LSB = 26;

endpackage

//--- src/vec_issue_queue.sv
// --------------------------------------------------------------------------
// vector issue queue
// in-order circular buffer of decoded entries between the decoder and
// the control generator, drained one entry per pop
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module vec_issue_queue
  import vec_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         push,
  input  vec_decoded_t entry,
  input  logic         pop,
  output logic         full,
  output logic         avail,
  output vec_decoded_t head
);

  vec_decoded_t        mem [QUEUE_DEPTH];
  logic [QUEUE_AW-1:0] wr_ptr;
  logic [QUEUE_AW-1:0] rd_ptr;
  logic [QUEUE_AW:0]   count;
  logic                do_push;
  logic                do_pop;

  // a push while full is dropped here, the sender must hold off
  assign do_push = push && !full;
  assign do_pop  = pop && avail;

  assign full  = (count == (QUEUE_AW + 1)'(QUEUE_DEPTH));
  assign avail = (count != '0);
  assign head  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= entry;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/vec_op_decoder.sv
// --------------------------------------------------------------------------
// vector operation decoder
// splits one instruction into its fields, checks funct6 against the
// allowed funct3 categories and produces the decoded queue entry
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module vec_op_decoder
  import vec_isa_pkg::*;
  import vec_ctrl_pkg::*;
(
  input  logic         instr_valid,
  input  instr_t       instr,
  input  sew_t         vtype_sew,
  output logic         push,
  output vec_decoded_t entry
);

  opcode_t   opcode;
  vfunct3_t  funct3;
  vopi_t     funct6_opi;
  vopm_t     funct6_opm;
  logic      is_vopi;
  logic      is_vopm;
  logic      f3_vv_vx;
  logic      f3_vx_vi;
  logic      f3_mvv;
  vec_op_t   op;
  src_type_t rs1_type;

  assign opcode     = opcode_t'(instr[6:0]);
  assign funct3     = vfunct3_t'(instr[FUNCT3_LSB +: 3]);
  assign funct6_opi = vopi_t'(instr[FUNCT6_LSB +: 6]);
  assign funct6_opm = vopm_t'(instr[FUNCT6_LSB +: 6]);

  assign is_vopi = (opcode == VECTOR) && (funct3 inside {OPIVV, OPIVX, OPIVI});
  assign is_vopm = (opcode == VECTOR) && (funct3 inside {OPMVV, OPMVX});

  // legal category subsets
  assign f3_vv_vx = (funct3 == OPIVV) || (funct3 == OPIVX);
  assign f3_vx_vi = (funct3 == OPIVX) || (funct3 == OPIVI);
  assign f3_mvv   = (funct3 == OPMVV);

  always_comb begin
    op = BAD_OP;
    if (is_vopi) begin
      case (funct6_opi)
        VADD:    op = OP_VADD;
        VSUB:    op = f3_vv_vx ? OP_VSUB : BAD_OP;
        VRSUB:   op = f3_vx_vi ? OP_VRSUB : BAD_OP;
        VMINU:   op = f3_vv_vx ? OP_VMINU : BAD_OP;
        VMIN:    op = f3_vv_vx ? OP_VMIN : BAD_OP;
        VMAXU:   op = f3_vv_vx ? OP_VMAXU : BAD_OP;
        VMAX:    op = f3_vv_vx ? OP_VMAX : BAD_OP;
        VAND:    op = OP_VAND;
        VOR:     op = OP_VOR;
        VXOR:    op = OP_VXOR;
        VMSEQ:   op = OP_VMSEQ;
        VMSNE:   op = OP_VMSNE;
        // no immediate form for the less-than compares
        VMSLTU:  op = f3_vv_vx ? OP_VMSLTU : BAD_OP;
        VMSLT:   op = f3_vv_vx ? OP_VMSLT : BAD_OP;
        VSLL:    op = OP_VSLL;
        VSRL:    op = OP_VSRL;
        VSRA:    op = OP_VSRA;
        default: op = BAD_OP;
      endcase
    end else if (is_vopm) begin
      case (funct6_opm)
        VREDSUM:  op = f3_mvv ? OP_VREDSUM : BAD_OP;
        VDIVU:    op = OP_VDIVU;
        VDIV:     op = OP_VDIV;
        VMUL:     op = OP_VMUL;
        VMULH:    op = OP_VMULH;
        VWADDU:   op = OP_VWADDU;
        VWADD:    op = OP_VWADD;
        VWADDU_W: op = OP_VWADDU_W;
        default:  op = BAD_OP;
      endcase
    end
  end

  always_comb begin
    case (funct3)
      OPIVX, OPMVX: rs1_type = X;
      OPIVI:        rs1_type = I;
      default:      rs1_type = V;
    endcase
  end

  assign push  = instr_valid;
  assign entry = '{
    op:       op,
    sew:      vtype_sew,
    vd:       reg_idx_t'(instr[VD_LSB +: 5]),
    vs1:      reg_idx_t'(instr[VS1_LSB +: 5]),
    vs2:      reg_idx_t'(instr[VS2_LSB +: 5]),
    rs1_type: rs1_type,
    illegal:  (op == BAD_OP)
  };

endmodule
